// File: files.f
verilog/ioPkg.sv
verilog/ioBus.sv
verilog/busDecoder.sv
verilog/keyCapture.sv
verilog/switchDebouncer.sv
verilog/intervalTimer.sv
verilog/displayPort.sv
verilog/ioController.sv
test/ioChecker.sv
test/ioControllerTb.sv

// File: test/ioControllerTb.sv
`timescale 1ns/1ps

module ioControllerTb;
	import ioPkg::*;

	localparam int clkPeriod = 100;
	localparam int tbTicksPerMs = 8;
	localparam int tbDebounceMs = 2;
	localparam int debounceCycles = tbTicksPerMs * tbDebounceMs;
	localparam int hexRounds = 8;
	localparam int keyRounds = 6;
	localparam int swRounds = 4;
	localparam int timerRounds = 3;
	localparam int timerSpan = 60;
	localparam int mixCycles = 200;
	// upper bound of stimulus cycles over reset, all tests and closing idles
	localparam int stimCycles = 2 + hexRounds * 4 + 1 + keyRounds * 13 +
		swRounds * (2 * debounceCycles + 8) + timerRounds * (timerSpan + 8) + 1 +
		mixCycles + 5 * 2;
	localparam int marginCycles = 100;

	logic clk;
	logic reset;
	logic [dataBits-1:0] busAddr;
	logic [dataBits-1:0] busWrData;
	logic busWrEn;
	logic busRdEn;
	logic [dataBits-1:0] busRdData;
	logic busRdValid;
	logic [switchCount-1:0] sw;
	logic [keyCount-1:0] key;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [switchCount-1:0] ledr;
	integer seed;
	logic [dataBits-1:0] addrList [0:10];

	ioController #(
		.ticksPerMs(tbTicksPerMs),
		.debounceMs(tbDebounceMs)
	) uut (.*);

	ioChecker #(
		.ticksPerMs(tbTicksPerMs),
		.debounceMs(tbDebounceMs)
	) chk (.*);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#((stimCycles + marginCycles) * clkPeriod);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	// one bus cycle driven just after the rising edge
	task automatic busCycle(input logic wr, input logic rd, input logic [dataBits-1:0] addr,
		input logic [dataBits-1:0] data);
		@(posedge clk);
		#5;
		busWrEn = wr;
		busRdEn = rd;
		busAddr = addr;
		busWrData = data;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
			busCycle(1'b0, 1'b0, '0, '0);
	endtask

	task automatic writeReg(input logic [dataBits-1:0] addr, input logic [dataBits-1:0] data);
		busCycle(1'b1, 1'b0, addr, data);
	endtask

	task automatic readReg(input logic [dataBits-1:0] addr);
		busCycle(1'b0, 1'b1, addr, '0);
	endtask

	function automatic logic [keyCount-1:0] randomKeys();
		logic [keyCount-1:0] pattern;
		pattern = $random(seed);
		if (pattern == '0)
			pattern = 4'h8;
		return pattern;
	endfunction

	// active-low keys held down for two edges
	task automatic pressKeys(input logic [keyCount-1:0] pattern);
		idle(1);
		key = ~pattern;
		idle(2);
		key = '1;
	endtask

	task automatic hexLedTest();
		chk.startTest("hexLed");
		readReg(addrHex);
		repeat (hexRounds) begin
			writeReg(addrHex, $random(seed));
			writeReg(addrLedr, $random(seed));
			readReg(addrHex);
			readReg(addrLedr);
		end
		idle(2);
		chk.finishTest();
	endtask

	task automatic keyPressTest();
		chk.startTest("keyPress");
		repeat (keyRounds) begin
			pressKeys(randomKeys());
			readReg(addrKeyCtl);
			// second press before the data read
			pressKeys(randomKeys());
			readReg(addrKeyCtl);
			readReg(addrKey);
			readReg(addrKeyCtl);
			writeReg(addrKeyCtl, '0);
			readReg(addrKeyCtl);
			readReg(addrKey);
		end
		idle(2);
		chk.finishTest();
	endtask

	task automatic switchTest();
		logic [switchCount-1:0] stable;
		logic [switchCount-1:0] glitch;
		int len;
		chk.startTest("switchDebounce");
		stable = sw;
		repeat (swRounds) begin
			glitch = $random(seed);
			if (glitch == stable)
				glitch = ~stable;
			len = 2 + $unsigned($random(seed)) % 11;
			sw = glitch;
			idle(len);
			sw = stable;
			idle(1);
			readReg(addrSw);
			// a real change held past the debounce time
			stable = $random(seed);
			sw = stable;
			idle(debounceCycles + 4);
			readReg(addrSwCtl);
			readReg(addrSw);
			readReg(addrSwCtl);
			writeReg(addrSwCtl, '0);
			idle(1);
		end
		idle(2);
		chk.finishTest();
	endtask

	task automatic timerTest();
		logic [dataBits-1:0] limit;
		chk.startTest("timer");
		repeat (timerRounds) begin
			limit = 2 + $unsigned($random(seed)) % 4;
			writeReg(addrTimerLim, limit);
			writeReg(addrTimerCnt, '0);
			repeat (timerSpan) begin
				if (($random(seed) & 3) == 0)
					readReg(addrTimerCnt);
				else
					idle(1);
			end
			readReg(addrTimerCtl);
			// random mask clears ready, overrun or both
			writeReg(addrTimerCtl, $random(seed) & 3);
			readReg(addrTimerCtl);
		end
		writeReg(addrTimerLim, '0);
		idle(2);
		chk.finishTest();
	endtask

	task automatic randomMixTest();
		int op;
		logic [dataBits-1:0] addr;
		logic [dataBits-1:0] data;
		chk.startTest("randomMix");
		repeat (mixCycles) begin
			op = $unsigned($random(seed)) % 4;
			addr = addrList[$unsigned($random(seed)) % 11];
			data = $random(seed);
			if (($random(seed) & 7) == 0)
				addr = $random(seed);
			if (addr == addrTimerLim || addr == addrTimerCnt)
				data = data & 32'h7;
			// reads weighted up so that back-to-back reads happen
			case (op)
				0: writeReg(addr, data);
				1, 2: readReg(addr);
				default: idle(1);
			endcase
			if (($random(seed) & 7) == 0)
				key = $random(seed);
			if (($random(seed) & 31) == 0)
				sw = $random(seed);
		end
		idle(2);
		chk.finishTest();
	endtask

	initial begin
		seed = 32'hcf10;
		reset = 1'b1;
		busAddr = '0;
		busWrData = '0;
		busWrEn = 1'b0;
		busRdEn = 1'b0;
		sw = '0;
		key = '1;
		addrList = '{addrHex, addrLedr, addrKey, addrKeyCtl, addrSw, addrSwCtl,
			addrTimerCnt, addrTimerLim, addrTimerCtl, 32'hFFFFF004, 32'hFFFFF10C};
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;

		hexLedTest();
		keyPressTest();
		switchTest();
		timerTest();
		randomMixTest();

		chk.printSummary();
		if (chk.errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/ioChecker.sv
`timescale 1ns/1ps

module ioChecker #(
	parameter int ticksPerMs = ioPkg::defaultTicksPerMs,
	parameter int debounceMs = ioPkg::defaultDebounceMs
) (
	input logic clk,
	input logic reset,
	input logic [ioPkg::dataBits-1:0] busAddr,
	input logic [ioPkg::dataBits-1:0] busWrData,
	input logic busWrEn,
	input logic busRdEn,
	input logic [ioPkg::dataBits-1:0] busRdData,
	input logic busRdValid,
	input logic [ioPkg::switchCount-1:0] sw,
	input logic [ioPkg::keyCount-1:0] key,
	input logic [6:0] hex0,
	input logic [6:0] hex1,
	input logic [6:0] hex2,
	input logic [6:0] hex3,
	input logic [6:0] hex4,
	input logic [6:0] hex5,
	input logic [ioPkg::switchCount-1:0] ledr
);
	import ioPkg::*;

	// reference model state
	int prescCnt;
	logic [keyCount-1:0] mKeyPrev;
	logic [keyCount-1:0] mKeyData;
	logic [1:0] mKeyCtl;
	logic [switchCount-1:0] mSwData;
	logic [switchCount-1:0] mSwLast;
	int swRun;
	logic [1:0] mSwCtl;
	logic [dataBits-1:0] mCount;
	logic [dataBits-1:0] mLimit;
	logic [1:0] mTimerCtl;
	logic [hexDigits*4-1:0] mHex;
	logic [switchCount-1:0] mLedr;
	logic expValid;
	logic [dataBits-1:0] expData;
	logic [dataBits-1:0] expAddr;
	logic [hexDigits*7-1:0] hexPins;

	string testName = "";
	logic active = 1'b0;
	int testChecks = 0;
	int testErrors = 0;
	int testsRun = 0;
	int checkCount = 0;
	int errorCount = 0;

	assign hexPins = {hex5, hex4, hex3, hex2, hex1, hex0};

	// table of lit segments gfedcba inverted for the active-low pins
	function automatic logic [6:0] segCode(input logic [3:0] digit);
		logic [6:0] lit;
		case (digit)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// ready survives unless masked off or cleared by a read
	// overrun needs the surviving ready
	function automatic logic [1:0] ctlNext(input logic [1:0] cur, input logic wr,
		input logic [1:0] mask, input logic clr, input logic evt);
		logic [1:0] result;
		logic keepReady;
		keepReady = cur[ctlReadyBit] & (~wr | mask[ctlReadyBit]) & ~clr;
		result[ctlReadyBit] = keepReady | evt;
		result[ctlOverrunBit] = (cur[ctlOverrunBit] & (~wr | mask[ctlOverrunBit])) |
			(evt & keepReady);
		return result;
	endfunction

	function automatic logic wrHit(input logic [dataBits-1:0] addr);
		return busWrEn && busAddr == addr;
	endfunction

	function automatic logic rdHit(input logic [dataBits-1:0] addr);
		return busRdEn && busAddr == addr;
	endfunction

	function automatic logic [dataBits-1:0] modelRead(input logic [dataBits-1:0] addr);
		case (addr)
			addrHex: return {8'h0, mHex};
			addrLedr: return {22'h0, mLedr};
			addrKey: return {28'h0, mKeyData};
			addrKeyCtl: return {30'h0, mKeyCtl};
			addrSw: return {22'h0, mSwData};
			addrSwCtl: return {30'h0, mSwCtl};
			addrTimerCnt: return mCount;
			addrTimerLim: return mLimit;
			addrTimerCtl: return {30'h0, mTimerCtl};
			default: return '0;
		endcase
	endfunction

	task automatic checkValue(input string what, input logic [dataBits-1:0] exp,
		input logic [dataBits-1:0] act);
		testChecks++;
		if (exp !== act) begin
			testErrors++;
			$display("Error %s: %s expected %h actual %h", testName, what, exp, act);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testChecks = 0;
		testErrors = 0;
		active = 1'b1;
	endtask

	task automatic finishTest();
		$display("%s: %0d checks, %0d errors, %s", testName, testChecks, testErrors,
			testErrors == 0 ? "passed" : "failed");
		checkCount += testChecks;
		errorCount += testErrors;
		testsRun++;
		active = 1'b0;
	endtask

	task automatic printSummary();
		$display("%0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
	endtask

	// one model step per edge from the inputs sampled at that edge
	always @(posedge clk or posedge reset) begin : modelStep
		logic tick;
		logic wrap;
		logic accept;
		logic [keyCount-1:0] press;
		if (reset) begin
			prescCnt = 0;
			mKeyPrev = '1;
			mKeyData = '0;
			mKeyCtl = '0;
			mSwData = '0;
			mSwLast = '0;
			swRun = 0;
			mSwCtl = '0;
			mCount = '0;
			mLimit = '0;
			mTimerCtl = '0;
			mHex = hexResetValue;
			mLedr = '0;
			expValid = 1'b0;
		end else begin
			// read data comes from the state before this edge
			expValid = busRdEn;
			if (busRdEn) begin
				expData = modelRead(busAddr);
				expAddr = busAddr;
			end

			tick = prescCnt == ticksPerMs - 1;
			wrap = tick && mLimit != 0 && mCount == mLimit - 1;
			prescCnt = tick ? 0 : prescCnt + 1;

			press = mKeyPrev & ~key;
			mKeyCtl = ctlNext(mKeyCtl, wrHit(addrKeyCtl), busWrData[1:0], rdHit(addrKey),
				|press);
			mKeyData = (rdHit(addrKey) ? '0 : mKeyData) | press;
			mKeyPrev = key;

			// run length of one value that differs from the stored one
			if (sw == mSwData)
				swRun = 0;
			else if (swRun > 0 && sw == mSwLast)
				swRun++;
			else
				swRun = 1;
			accept = swRun == debounceMs * ticksPerMs;
			if (accept) begin
				mSwData = sw;
				swRun = 0;
			end
			mSwLast = sw;
			mSwCtl = ctlNext(mSwCtl, wrHit(addrSwCtl), busWrData[1:0], rdHit(addrSw), accept);

			if (wrHit(addrTimerCnt))
				mCount = busWrData;
			else if (wrap)
				mCount = '0;
			else if (tick)
				mCount = mCount + 1;
			if (wrHit(addrTimerLim))
				mLimit = busWrData;
			mTimerCtl = ctlNext(mTimerCtl, wrHit(addrTimerCtl), busWrData[1:0], 1'b0, wrap);

			if (wrHit(addrHex))
				mHex = busWrData[hexDigits*4-1:0];
			if (wrHit(addrLedr))
				mLedr = busWrData[switchCount-1:0];
		end
	end

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (active && !reset) begin
			checkValue("busRdValid", expValid, busRdValid);
			if (expValid)
				checkValue($sformatf("read of %h", expAddr), expData, busRdData);
			for (int d = 0; d < hexDigits; d++)
				checkValue($sformatf("hex%0d", d), segCode(mHex[d*4 +: 4]), hexPins[d*7 +: 7]);
			checkValue("ledr", mLedr, ledr);
		end
	end

endmodule

// File: verilog/ioController.sv
`timescale 1ns/1ps

module ioController #(
	parameter int ticksPerMs = ioPkg::defaultTicksPerMs,
	parameter int debounceMs = ioPkg::defaultDebounceMs
) (
	input logic clk,
	input logic reset,
	input logic [ioPkg::dataBits-1:0] busAddr,
	input logic [ioPkg::dataBits-1:0] busWrData,
	input logic busWrEn,
	input logic busRdEn,
	output logic [ioPkg::dataBits-1:0] busRdData,
	output logic busRdValid,
	input logic [ioPkg::switchCount-1:0] sw,
	input logic [ioPkg::keyCount-1:0] key,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [ioPkg::switchCount-1:0] ledr
);

	ioBus keyBus ();
	ioBus swBus ();
	ioBus timerBus ();
	ioBus dispBus ();

	busDecoder decoder (
		.clk(clk),
		.reset(reset),
		.busAddr(busAddr),
		.busWrData(busWrData),
		.busWrEn(busWrEn),
		.busRdEn(busRdEn),
		.busRdData(busRdData),
		.busRdValid(busRdValid),
		.keyBus(keyBus.decoder),
		.swBus(swBus.decoder),
		.timerBus(timerBus.decoder),
		.dispBus(dispBus.decoder)
	);

	// input side
	keyCapture keys (
		.clk(clk),
		.reset(reset),
		.key(key),
		.bus(keyBus.device)
	);

	switchDebouncer #(
		.ticksPerMs(ticksPerMs),
		.debounceMs(debounceMs)
	) switches (
		.clk(clk),
		.reset(reset),
		.sw(sw),
		.bus(swBus.device)
	);

	intervalTimer #(
		.ticksPerMs(ticksPerMs)
	) timer (
		.clk(clk),
		.reset(reset),
		.bus(timerBus.device)
	);

	// output side
	displayPort display (
		.clk(clk),
		.reset(reset),
		.bus(dispBus.device),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

endmodule

// File: verilog/displayPort.sv
`timescale 1ns/1ps

module displayPort (
	input logic clk,
	input logic reset,
	ioBus.device bus,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [ioPkg::switchCount-1:0] ledr
);
	import ioPkg::*;

	logic [hexDigits*4-1:0] hexReg;
	// one red LED sits above each switch
	logic [switchCount-1:0] ledrReg;
	logic hexWr;
	logic ledrWr;

	// segments gfedcba where a zero lights the segment
	function automatic logic [6:0] sevenSeg(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	// hex register at regData and LEDs at regCtl
	assign hexWr = bus.wrEn && bus.sel == regData;
	assign ledrWr = bus.wrEn && bus.sel == regCtl;

	always_comb begin
		bus.rdData = '0;
		case (bus.sel)
			regData: bus.rdData = dataBits'(hexReg);
			regCtl: bus.rdData = dataBits'(ledrReg);
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexReg <= hexResetValue;
			ledrReg <= '0;
		end else begin
			if (hexWr)
				hexReg <= bus.wrData[hexDigits*4-1:0];
			if (ledrWr)
				ledrReg <= bus.wrData[switchCount-1:0];
		end
	end

	// digit 0 is the rightmost display
	assign hex0 = sevenSeg(hexReg[3:0]);
	assign hex1 = sevenSeg(hexReg[7:4]);
	assign hex2 = sevenSeg(hexReg[11:8]);
	assign hex3 = sevenSeg(hexReg[15:12]);
	assign hex4 = sevenSeg(hexReg[19:16]);
	assign hex5 = sevenSeg(hexReg[23:20]);

	assign ledr = ledrReg;

endmodule

// File: verilog/intervalTimer.sv
`timescale 1ns/1ps

module intervalTimer #(
	parameter int ticksPerMs = ioPkg::defaultTicksPerMs
) (
	input logic clk,
	input logic reset,
	ioBus.device bus
);
	import ioPkg::*;

	typedef logic [$clog2(ticksPerMs + 1)-1:0] prescCount;

	prescCount presc;
	logic tick;
	logic limHit;
	logic [dataBits-1:0] count;
	logic [dataBits-1:0] limit;
	logic [1:0] timerCtl;
	logic cntWr;
	logic limWr;
	logic ctlWr;

	// one pulse per millisecond
	assign tick = presc == prescCount'(ticksPerMs - 1);

	// a zero limit lets the count run freely
	assign limHit = tick && limit != '0 && count == limit - 1'b1;

	assign cntWr = bus.wrEn && bus.sel == regData;
	assign limWr = bus.wrEn && bus.sel == regLimit;
	assign ctlWr = bus.wrEn && bus.sel == regCtl;

	always_comb begin
		bus.rdData = '0;
		case (bus.sel)
			regData: bus.rdData = count;
			regLimit: bus.rdData = limit;
			regCtl: bus.rdData = dataBits'(timerCtl);
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			presc <= '0;
		else if (tick)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			limit <= '0;
			timerCtl <= '0;
		end else begin
			// a software write to the count wins over the tick
			if (cntWr)
				count <= bus.wrData;
			else if (limHit)
				count <= '0;
			else if (tick)
				count <= count + 1'b1;
			if (limWr)
				limit <= bus.wrData;
			timerCtl <= nextCtl(timerCtl, ctlWr, bus.wrData[ctlOverrunBit:ctlReadyBit],
				1'b0, limHit);
		end
	end

endmodule

// File: verilog/switchDebouncer.sv
`timescale 1ns/1ps

module switchDebouncer #(
	parameter int ticksPerMs = ioPkg::defaultTicksPerMs,
	parameter int debounceMs = ioPkg::defaultDebounceMs
) (
	input logic clk,
	input logic reset,
	input logic [ioPkg::switchCount-1:0] sw,
	ioBus.device bus
);
	import ioPkg::*;

	typedef logic [$clog2(debounceMs * ticksPerMs + 1)-1:0] stableCount;

	logic [switchCount-1:0] swData;
	// the value currently being timed
	logic [switchCount-1:0] swCand;
	logic [1:0] swCtl;
	stableCount stableCnt;
	logic accept;
	logic dataRd;
	logic ctlWr;

	// last cycle of a stable run that differs from the stored value
	assign accept = sw != swData && sw == swCand &&
		stableCnt == stableCount'(debounceMs * ticksPerMs - 1);

	assign dataRd = bus.rdEn && bus.sel == regData;
	assign ctlWr = bus.wrEn && bus.sel == regCtl;

	always_comb begin
		bus.rdData = '0;
		case (bus.sel)
			regData: bus.rdData = dataBits'(swData);
			regCtl: bus.rdData = dataBits'(swCtl);
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			swData <= '0;
			swCand <= '0;
			stableCnt <= '0;
			swCtl <= '0;
		end else begin
			if (sw == swData) begin
				stableCnt <= '0;
			end else if (sw != swCand) begin
				// restart timing when the input moves to a new value
				swCand <= sw;
				stableCnt <= stableCount'(1);
			end else if (accept) begin
				swData <= sw;
				stableCnt <= '0;
			end else begin
				stableCnt <= stableCnt + 1'b1;
			end
			swCtl <= nextCtl(swCtl, ctlWr, bus.wrData[ctlOverrunBit:ctlReadyBit],
				dataRd, accept);
		end
	end

endmodule

// File: verilog/keyCapture.sv
`timescale 1ns/1ps

module keyCapture (
	input logic clk,
	input logic reset,
	input logic [ioPkg::keyCount-1:0] key,
	ioBus.device bus
);
	import ioPkg::*;

	logic [keyCount-1:0] prevKey;
	logic [keyCount-1:0] keyData;
	logic [1:0] keyCtl;
	logic [keyCount-1:0] press;
	logic dataRd;
	logic ctlWr;

	// active-low keys so a press is a 1 to 0 step between samples
	assign press = prevKey & ~key;

	assign dataRd = bus.rdEn && bus.sel == regData;
	assign ctlWr = bus.wrEn && bus.sel == regCtl;

	always_comb begin
		bus.rdData = '0;
		case (bus.sel)
			regData: bus.rdData = dataBits'(keyData);
			regCtl: bus.rdData = dataBits'(keyCtl);
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prevKey <= '1;
			keyData <= '0;
			keyCtl <= '0;
		end else begin
			prevKey <= key;
			// presses accumulate until the data register is read
			keyData <= (dataRd ? '0 : keyData) | press;
			keyCtl <= nextCtl(keyCtl, ctlWr, bus.wrData[ctlOverrunBit:ctlReadyBit],
				dataRd, |press);
		end
	end

endmodule

// File: verilog/busDecoder.sv
`timescale 1ns/1ps

module busDecoder (
	input logic clk,
	input logic reset,
	input logic [ioPkg::dataBits-1:0] busAddr,
	input logic [ioPkg::dataBits-1:0] busWrData,
	input logic busWrEn,
	input logic busRdEn,
	output logic [ioPkg::dataBits-1:0] busRdData,
	output logic busRdValid,
	ioBus.decoder keyBus,
	ioBus.decoder swBus,
	ioBus.decoder timerBus,
	ioBus.decoder dispBus
);
	import ioPkg::*;

	logic hitKey;
	logic hitSw;
	logic hitTimer;
	logic hitDisp;
	devReg regSel;
	logic [dataBits-1:0] rdMux;

	// the only place where addresses are compared
	always_comb begin
		{hitKey, hitSw, hitTimer, hitDisp} = 4'b0000;
		regSel = regData;
		case (busAddr)
			addrHex: hitDisp = 1'b1;
			addrLedr: begin
				hitDisp = 1'b1;
				regSel = regCtl;
			end
			addrKey: hitKey = 1'b1;
			addrKeyCtl: begin
				hitKey = 1'b1;
				regSel = regCtl;
			end
			addrSw: hitSw = 1'b1;
			addrSwCtl: begin
				hitSw = 1'b1;
				regSel = regCtl;
			end
			addrTimerCnt: hitTimer = 1'b1;
			addrTimerLim: begin
				hitTimer = 1'b1;
				regSel = regLimit;
			end
			addrTimerCtl: begin
				hitTimer = 1'b1;
				regSel = regCtl;
			end
			default: ;
		endcase
	end

	assign keyBus.wrEn = busWrEn && hitKey;
	assign keyBus.rdEn = busRdEn && hitKey;
	assign swBus.wrEn = busWrEn && hitSw;
	assign swBus.rdEn = busRdEn && hitSw;
	assign timerBus.wrEn = busWrEn && hitTimer;
	assign timerBus.rdEn = busRdEn && hitTimer;
	assign dispBus.wrEn = busWrEn && hitDisp;
	assign dispBus.rdEn = busRdEn && hitDisp;

	assign keyBus.sel = regSel;
	assign swBus.sel = regSel;
	assign timerBus.sel = regSel;
	assign dispBus.sel = regSel;

	assign keyBus.wrData = busWrData;
	assign swBus.wrData = busWrData;
	assign timerBus.wrData = busWrData;
	assign dispBus.wrData = busWrData;

	// unmapped reads fall through to zero
	assign rdMux = hitKey ? keyBus.rdData :
		hitSw ? swBus.rdData :
		hitTimer ? timerBus.rdData :
		hitDisp ? dispBus.rdData : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			busRdValid <= 1'b0;
		else
			busRdValid <= busRdEn;
	end

	always_ff @(posedge clk) begin
		if (busRdEn)
			busRdData <= rdMux;
	end

endmodule

// File: verilog/ioBus.sv
`timescale 1ns/1ps

interface ioBus;
	import ioPkg::*;

	logic wrEn;
	logic rdEn;
	devReg sel;
	logic [dataBits-1:0] wrData;
	// driven combinationally by the device from its current registers
	logic [dataBits-1:0] rdData;

	modport decoder (
		output wrEn,
		output rdEn,
		output sel,
		output wrData,
		input rdData
	);

	modport device (
		input wrEn,
		input rdEn,
		input sel,
		input wrData,
		output rdData
	);

endinterface

// File: verilog/ioPkg.sv
package ioPkg;

	localparam int dataBits = 32;

	// memory-mapped register addresses
	localparam logic [dataBits-1:0] addrHex = 32'hFFFFF000;
	localparam logic [dataBits-1:0] addrLedr = 32'hFFFFF020;
	localparam logic [dataBits-1:0] addrKey = 32'hFFFFF080;
	localparam logic [dataBits-1:0] addrKeyCtl = 32'hFFFFF084;
	localparam logic [dataBits-1:0] addrSw = 32'hFFFFF090;
	localparam logic [dataBits-1:0] addrSwCtl = 32'hFFFFF094;
	localparam logic [dataBits-1:0] addrTimerCnt = 32'hFFFFF100;
	localparam logic [dataBits-1:0] addrTimerLim = 32'hFFFFF104;
	localparam logic [dataBits-1:0] addrTimerCtl = 32'hFFFFF108;

	localparam int keyCount = 4;
	localparam int switchCount = 10;
	localparam int hexDigits = 6;
	localparam logic [hexDigits*4-1:0] hexResetValue = 24'hFEDEAD;

	// 96 MHz core clock
	localparam int defaultTicksPerMs = 96000;
	localparam int defaultDebounceMs = 10;

	// same layout in every control register
	localparam int ctlReadyBit = 0;
	localparam int ctlOverrunBit = 1;

	// which register inside a device an access targets
	typedef enum logic [1:0] {
		regData,
		regCtl,
		regLimit
	} devReg;

	// next control state after a masked write and a read clear of ready
	// an event then sets ready and also overrun if ready was still up
	function automatic logic [1:0] nextCtl(
		input logic [1:0] ctl,
		input logic wr,
		input logic [1:0] mask,
		input logic rdClr,
		input logic set
	);
		logic [1:0] result;
		result = wr ? (ctl & mask) : ctl;
		if (rdClr)
			result[ctlReadyBit] = 1'b0;
		if (set) begin
			result[ctlOverrunBit] = result[ctlOverrunBit] | result[ctlReadyBit];
			result[ctlReadyBit] = 1'b1;
		end
		return result;
	endfunction

endpackage
